//--- hdl/monitor_pkg.sv
// ADC window monitor definitions
package monitor_pkg;

    // Sample path
    localparam int sample_w = 12;     // Sample and bound width
    localparam int num_chan = 4;
    localparam int chan_w   = 2;

    // Event queue
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = fifo_ptr_w + 1;   // Holds 0..fifo_depth

    // Output flow control
    localparam int credit_init = 4;   // Credits granted by the consumer at reset
    localparam int credit_w    = 3;

    localparam int drop_w = 16;       // Saturating drop counter

    typedef enum logic [1:0] {
        ev_exit     = 2'd0,           // Channel left its window
        ev_enter    = 2'd1,           // Channel came back into its window
        ev_boundary = 2'd2            // Sample sits on a bound, no state change
    } event_kind_t;

    // Event word, kind in the top bits
    typedef struct packed {
        event_kind_t         kind;
        logic [chan_w-1:0]   chan;
        logic [sample_w-1:0] sample;
    } event_t;

endpackage

//--- hdl/bound_regs.sv
// Channel bound and enable registers
module bound_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cfg_we,
    input  logic [monitor_pkg::chan_w-1:0]   cfg_chan,
    input  logic                             cfg_upper,
    input  logic [monitor_pkg::sample_w-1:0] cfg_data,
    input  logic                             cfg_en_we,
    input  logic [monitor_pkg::num_chan-1:0] cfg_en_mask,
    input  logic [monitor_pkg::chan_w-1:0]   rd_chan,
    output logic [monitor_pkg::sample_w-1:0] rd_lower,
    output logic [monitor_pkg::sample_w-1:0] rd_upper,
    output logic                             rd_en
);
    import monitor_pkg::*;

    logic [sample_w-1:0] lower_q [num_chan];
    logic [sample_w-1:0] upper_q [num_chan];
    logic [num_chan-1:0] en_q;

    // One bound per write, selected by cfg_upper
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_chan; i++) begin
                lower_q[i] <= '0;
                upper_q[i] <= '0;
            end
        end else if (cfg_we) begin
            if (cfg_upper) begin
                upper_q[cfg_chan] <= cfg_data;
            end else begin
                lower_q[cfg_chan] <= cfg_data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= '0;                   // All channels off after reset
        end else if (cfg_en_we) begin
            en_q <= cfg_en_mask;
        end
    end

    // Window of the channel being sampled
    assign rd_lower = lower_q[rd_chan];
    assign rd_upper = upper_q[rd_chan];
    assign rd_en    = en_q[rd_chan];

endmodule

//--- hdl/window_comparator.sv
// Pipelined window comparator
module window_comparator (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic [monitor_pkg::chan_w-1:0]   in_chan,
    input  logic                             in_en,
    input  logic [monitor_pkg::sample_w-1:0] data_value,
    input  logic [monitor_pkg::sample_w-1:0] lower_bound,
    input  logic [monitor_pkg::sample_w-1:0] upper_bound,
    output logic                             cmp_valid,
    output logic [monitor_pkg::chan_w-1:0]   cmp_chan,
    output logic                             cmp_en,
    output logic [monitor_pkg::sample_w-1:0] cmp_sample,
    output logic                             in_range,
    output logic                             out_of_range,
    output logic                             at_boundary
);
    import monitor_pkg::*;

    // Stage 1, captured inputs
    logic                valid_s1, en_s1;
    logic [chan_w-1:0]   chan_s1;
    logic [sample_w-1:0] data_s1, lower_s1, upper_s1;

    // Stage 2, raw comparisons
    logic                valid_s2, en_s2;
    logic [chan_w-1:0]   chan_s2;
    logic [sample_w-1:0] data_s2;
    logic                below_s2, above_s2, eq_lower_s2, eq_upper_s2;

    // Valid flags of the three stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            cmp_valid <= 1'b0;
        end else begin
            valid_s1  <= in_valid;
            valid_s2  <= valid_s1;
            cmp_valid <= valid_s2;
        end
    end

    always_ff @(posedge clk) begin
        {chan_s1, en_s1, data_s1} <= {in_chan, in_en, data_value};
        lower_s1                  <= lower_bound;
        upper_s1                  <= upper_bound;

        {chan_s2, en_s2, data_s2} <= {chan_s1, en_s1, data_s1};
        below_s2    <= data_s1 < lower_s1;
        above_s2    <= data_s1 > upper_s1;
        eq_lower_s2 <= data_s1 == lower_s1;
        eq_upper_s2 <= data_s1 == upper_s1;

        {cmp_chan, cmp_en, cmp_sample} <= {chan_s2, en_s2, data_s2};
        out_of_range <= below_s2 | above_s2;
        in_range     <= ~(below_s2 | above_s2);
        at_boundary  <= eq_lower_s2 | eq_upper_s2;   // Either bound hit
    end

endmodule

//--- hdl/monitor_ctrl.sv
// Window event generator
module monitor_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cmp_valid,
    input  logic [monitor_pkg::chan_w-1:0]   cmp_chan,
    input  logic                             cmp_en,
    input  logic [monitor_pkg::sample_w-1:0] cmp_sample,
    input  logic                             in_range,
    input  logic                             at_boundary,
    input  logic                             fifo_full,
    output logic                             push,
    output monitor_pkg::event_t              push_data,
    output logic [monitor_pkg::drop_w-1:0]   drop_count
);
    import monitor_pkg::*;

    logic [num_chan-1:0] prev_in;     // Last known in-range state per channel
    logic                prev;
    logic                ev_hit;
    event_kind_t         ev_kind;
    logic                ev_pending;  // Event waiting to enter the FIFO
    event_t              ev_word;

    assign prev = prev_in[cmp_chan];

    // A transition wins over a boundary hit
    always_comb begin
        ev_hit  = 1'b0;
        ev_kind = ev_boundary;
        if (cmp_valid && cmp_en) begin
            if (prev && !in_range) begin
                ev_hit  = 1'b1;
                ev_kind = ev_exit;
            end else if (!prev && in_range) begin
                ev_hit  = 1'b1;
                ev_kind = ev_enter;
            end else if (at_boundary) begin
                ev_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_in    <= '1;              // Every channel starts in range
            ev_pending <= 1'b0;
            drop_count <= '0;
        end else begin
            if (cmp_valid && cmp_en) begin
                prev_in[cmp_chan] <= in_range;
            end
            ev_pending <= ev_hit;
            if (ev_pending && fifo_full && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;   // Saturates at all ones
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ev_hit) begin
            ev_word <= '{kind: ev_kind, chan: cmp_chan, sample: cmp_sample};
        end
    end

    // Events meeting a full FIFO are counted instead of pushed
    assign push      = ev_pending && !fifo_full;
    assign push_data = ev_word;

endmodule

//--- hdl/event_fifo.sv
// Event FIFO
module event_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  monitor_pkg::event_t push_data,
    input  logic                pop,
    output monitor_pkg::event_t pop_data,
    output logic                full,
    output logic                empty
);
    import monitor_pkg::*;

    event_t                mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr, rd_ptr;    // Wrap naturally, depth is a power of two
    logic [fifo_cnt_w-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];                // Head word
    assign full     = count == fifo_cnt_w'(fifo_depth);
    assign empty    = count == '0;

endmodule

//--- hdl/credit_tx.sv
// Credit based event sender
module credit_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fifo_empty,
    input  monitor_pkg::event_t fifo_data,
    input  logic                credit_return,
    output logic                pop,
    output logic                event_valid,
    output monitor_pkg::event_t event_data
);
    import monitor_pkg::*;

    logic [credit_w-1:0] credits;

    // Send whenever a word is waiting and the consumer has room
    assign pop = !fifo_empty && credits != '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits     <= credit_w'(credit_init);
            event_valid <= 1'b0;
        end else begin
            event_valid <= pop;
            case ({credit_return, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;      // Return and send cancel out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            event_data <= fifo_data;
        end
    end

endmodule

//--- hdl/adc_window_monitor.sv
// ADC window monitor top
module adc_window_monitor (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cfg_we,
    input  logic [monitor_pkg::chan_w-1:0]   cfg_chan,
    input  logic                             cfg_upper,
    input  logic [monitor_pkg::sample_w-1:0] cfg_data,
    input  logic                             cfg_en_we,
    input  logic [monitor_pkg::num_chan-1:0] cfg_en_mask,
    input  logic                             sample_valid,
    input  logic [monitor_pkg::chan_w-1:0]   sample_chan,
    input  logic [monitor_pkg::sample_w-1:0] sample_data,
    input  logic                             credit_return,
    output logic                             event_valid,
    output monitor_pkg::event_t              event_data,
    output logic [monitor_pkg::drop_w-1:0]   drop_count
);
    import monitor_pkg::*;

    // Selected window of the incoming sample
    logic [sample_w-1:0] rd_lower, rd_upper;
    logic                rd_en;

    // Classified sample
    logic                cmp_valid, cmp_en, in_range, at_boundary;
    logic [chan_w-1:0]   cmp_chan;
    logic [sample_w-1:0] cmp_sample;

    // FIFO side
    logic                push, pop, fifo_full, fifo_empty;
    event_t              push_data, pop_data;

    bound_regs u_bound_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg_chan    (cfg_chan),
        .cfg_upper   (cfg_upper),
        .cfg_data    (cfg_data),
        .cfg_en_we   (cfg_en_we),
        .cfg_en_mask (cfg_en_mask),
        .rd_chan     (sample_chan),
        .rd_lower    (rd_lower),
        .rd_upper    (rd_upper),
        .rd_en       (rd_en)
    );

    window_comparator u_window_comparator (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (sample_valid),
        .in_chan      (sample_chan),
        .in_en        (rd_en),
        .data_value   (sample_data),
        .lower_bound  (rd_lower),
        .upper_bound  (rd_upper),
        .cmp_valid    (cmp_valid),
        .cmp_chan     (cmp_chan),
        .cmp_en       (cmp_en),
        .cmp_sample   (cmp_sample),
        .in_range     (in_range),
        .out_of_range (),
        .at_boundary  (at_boundary)
    );

    monitor_ctrl u_monitor_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmp_valid   (cmp_valid),
        .cmp_chan    (cmp_chan),
        .cmp_en      (cmp_en),
        .cmp_sample  (cmp_sample),
        .in_range    (in_range),
        .at_boundary (at_boundary),
        .fifo_full   (fifo_full),
        .push        (push),
        .push_data   (push_data),
        .drop_count  (drop_count)
    );

    event_fifo u_event_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    credit_tx u_credit_tx (
        .clk           (clk),
        .rst_n         (rst_n),
        .fifo_empty    (fifo_empty),
        .fifo_data     (pop_data),
        .credit_return (credit_return),
        .pop           (pop),
        .event_valid   (event_valid),
        .event_data    (event_data)
    );

endmodule

//--- verification/tb_adc_window_monitor.sv
// ADC window monitor testbench
module tb_adc_window_monitor;
    timeunit 1ns;
    timeprecision 1ps;
    import monitor_pkg::*;

    localparam int n_sweep       = 300;
    localparam int k_burst       = 20;       // Event-producing samples during the credit stall
    localparam int total_samples = 1 + 6 + 5 + n_sweep + k_burst;
    localparam int timeout_limit = 20 * total_samples + 1000;

    logic                clk, rst_n;
    logic                cfg_we, cfg_upper, cfg_en_we;
    logic [chan_w-1:0]   cfg_chan, sample_chan;
    logic [sample_w-1:0] cfg_data, sample_data;
    logic [num_chan-1:0] cfg_en_mask;
    logic                sample_valid, credit_return, event_valid;
    event_t              event_data;
    logic [drop_w-1:0]   drop_count;

    // Reference model state
    logic [sample_w-1:0] lower_m [num_chan];
    logic [sample_w-1:0] upper_m [num_chan];
    logic [num_chan-1:0] en_m      = '0;
    logic [num_chan-1:0] prev_m    = '1;
    logic [drop_w-1:0]   exp_drops = '0;
    event_t              exp_q [$];
    int unsigned         recv_count = 0;
    bit                  withhold   = 1'b0;   // Consumer keeps its credits

    adc_window_monitor u_adc_window_monitor (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_event(input string name, input event_t got, input event_t exp);
        if (got !== exp) fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_count(input string name, input logic [drop_w-1:0] got,
                               input logic [drop_w-1:0] exp);
        if (got !== exp) fail_run($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Drives one sample and queues the event the window rules call for
    task automatic send_sample(input logic [chan_w-1:0] ch, input logic [sample_w-1:0] value);
        logic   in_win, on_bound;
        event_t ev;
        @(posedge clk);
        #1;
        sample_valid = 1'b1;
        sample_chan  = ch;
        sample_data  = value;
        if (en_m[ch]) begin
            in_win    = value >= lower_m[ch] && value <= upper_m[ch];
            on_bound  = value == lower_m[ch] || value == upper_m[ch];
            ev.chan   = ch;
            ev.sample = value;
            ev.kind   = ev_boundary;
            if (prev_m[ch] && !in_win) ev.kind = ev_exit;
            else if (!prev_m[ch] && in_win) ev.kind = ev_enter;
            if (prev_m[ch] != in_win || on_bound) exp_q.push_back(ev);
            prev_m[ch] = in_win;
        end
    endtask

    task automatic stop_samples();
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic write_window(input logic [chan_w-1:0] ch, input logic [sample_w-1:0] lo,
                                input logic [sample_w-1:0] hi);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_chan  = ch;
        cfg_upper = 1'b0;
        cfg_data  = lo;
        @(posedge clk);
        #1;
        cfg_upper = 1'b1;
        cfg_data  = hi;
        @(posedge clk);
        #1;
        cfg_we      = 1'b0;
        lower_m[ch] = lo;
        upper_m[ch] = hi;
    endtask

    task automatic write_enable(input logic [num_chan-1:0] mask);
        @(posedge clk);
        #1;
        cfg_en_we   = 1'b1;
        cfg_en_mask = mask;
        @(posedge clk);
        #1;
        cfg_en_we = 1'b0;
        en_m      = mask;
    endtask

    // Waits until every queued event came out, then lets the pipeline settle
    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);
    endtask

    // Consumer, checks each event and returns its credit 0 to 3 cycles later
    initial begin
        int unsigned tick;
        int unsigned due_q [$];
        tick          = 0;
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            tick++;
            if (event_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("an event arrived while none was expected");
                end else begin
                    check_event("event_data", event_data, exp_q.pop_front());
                    recv_count++;
                    due_q.push_back(tick + $urandom_range(0, 3));
                end
            end
            #1;
            credit_return = 1'b0;
            if (!withhold && due_q.size() != 0 && due_q[0] <= tick) begin
                void'(due_q.pop_front());
                credit_return = 1'b1;
            end
        end
    end

    initial begin
        int unsigned cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_limit) fail_run("timeout, the run did not finish in time");
        end
    end

    initial begin
        logic [chan_w-1:0]   ch;
        logic [sample_w-1:0] lo, value;
        int unsigned         base, pick;
        void'($urandom(32'h9f6));
        {cfg_we, cfg_upper, cfg_en_we, cfg_chan, cfg_data, cfg_en_mask} = '0;
        {sample_valid, sample_chan, sample_data} = '0;
        for (int i = 0; i < num_chan; i++) begin
            lower_m[i] = '0;
            upper_m[i] = '0;
        end
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state, then the first excursion must be an exit
        repeat (4) @(posedge clk);
        check_count("drop_count", drop_count, '0);
        write_window(2'd0, 12'h400, 12'h800);
        write_enable(4'b0001);
        send_sample(2'd0, 12'h900);
        stop_samples();
        wait_drain();

        // Samples on both bounds, before and after leaving the window
        write_window(2'd2, 12'h100, 12'h300);
        write_enable(4'b0101);
        send_sample(2'd2, 12'h100);
        send_sample(2'd2, 12'h300);
        send_sample(2'd2, 12'h050);
        send_sample(2'd2, 12'h300);
        send_sample(2'd2, 12'h200);
        send_sample(2'd2, 12'h100);
        stop_samples();
        wait_drain();

        // Channel 1 leaves, is masked off, and must keep its out state
        write_window(2'd1, 12'h400, 12'h800);
        write_enable(4'b0011);
        send_sample(2'd1, 12'h900);
        stop_samples();
        wait_drain();
        write_enable(4'b0001);
        send_sample(2'd1, 12'h500);
        send_sample(2'd1, 12'h400);
        stop_samples();
        wait_drain();
        write_enable(4'b0011);
        send_sample(2'd1, 12'h950);
        send_sample(2'd1, 12'h500);
        stop_samples();
        wait_drain();

        // Random sweep, every sample followed by an idle cycle or two
        for (int c = 0; c < num_chan; c++) begin
            lo = sample_w'($urandom_range(0, 'hc00));
            write_window(chan_w'(c), lo, lo + sample_w'($urandom_range('h100, 'h3ff)));
        end
        write_enable(4'b1111);
        for (int i = 0; i < n_sweep; i++) begin
            ch    = chan_w'($urandom_range(0, num_chan - 1));
            pick  = $urandom_range(0, 7);
            value = sample_w'($urandom_range(0, 'hfff));
            if (pick == 0) value = lower_m[ch];
            if (pick == 1) value = upper_m[ch];
            send_sample(ch, value);
            stop_samples();
            if ($urandom_range(0, 1) == 1) @(posedge clk);
        end
        wait_drain();
        check_count("drop_count", drop_count, exp_drops);

        // Credit stall, every sample toggles the window state of channel 3
        write_window(2'd3, 12'h200, 12'h400);
        withhold = 1'b1;
        base     = recv_count;
        for (int i = 0; i < k_burst; i++) send_sample(2'd3, prev_m[3] ? 12'h100 : 12'h300);
        stop_samples();
        while (recv_count - base < credit_init) @(posedge clk);
        repeat (8) @(posedge clk);
        if (recv_count - base != credit_init) fail_run("more events sent than credits granted");
        exp_drops = drop_w'(k_burst - credit_init - fifo_depth);
        check_count("drop_count", drop_count, exp_drops);
        while (exp_q.size() > fifo_depth) void'(exp_q.pop_back());   // Dropped events

        // Refill, only the buffered events may follow
        withhold = 1'b0;
        wait_drain();
        check_count("drop_count", drop_count, exp_drops);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- filelist.f
hdl/monitor_pkg.sv
hdl/bound_regs.sv
hdl/window_comparator.sv
hdl/monitor_ctrl.sv
hdl/event_fifo.sv
hdl/credit_tx.sv
hdl/adc_window_monitor.sv
verification/tb_adc_window_monitor.sv

//--- Bender.yml
package:
  name: adc_window_monitor

sources:
  - hdl/monitor_pkg.sv
  - hdl/bound_regs.sv
  - hdl/window_comparator.sv
  - hdl/monitor_ctrl.sv
  - hdl/event_fifo.sv
  - hdl/credit_tx.sv
  - hdl/adc_window_monitor.sv
  - target: test
    files:
      - verification/tb_adc_window_monitor.sv
